// File: common/pmp_pkg.sv
package pmp_pkg;

  // Address matching mode of one entry
  typedef enum logic [1:0] {
    PMP_OFF   = 2'b00,
    PMP_TOR   = 2'b01,
    PMP_NA4   = 2'b10,
    PMP_NAPOT = 2'b11
  } pmp_mode_e;

  // One pmpcfg byte, MSB first
  typedef struct packed {
    logic      lock;
    logic [1:0] zero;
    pmp_mode_e mode;
    logic      exec;
    logic      write;
    logic      read;
  } pmp_cfg_t;

  typedef enum logic [1:0] {
    PMP_ACC_EXEC  = 2'b00,
    PMP_ACC_READ  = 2'b01,
    PMP_ACC_WRITE = 2'b10
  } pmp_acc_e;

  typedef enum logic [1:0] {
    PMP_PRIV_U = 2'b00,
    PMP_PRIV_M = 2'b11
  } pmp_priv_e;

  // Register window selected by an APB access
  typedef enum logic [1:0] {
    PMP_SEL_CFG     = 2'b00,
    PMP_SEL_ADDR    = 2'b01,
    PMP_SEL_MSECCFG = 2'b10
  } pmp_sel_e;

  // Size code is log2 of the byte count: 0 = 1, 1 = 2, 2 = 4 bytes
  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
    pmp_acc_e    acc;
    pmp_priv_e   priv;
    logic [1:0]  size;
  } pmp_req_t;

  typedef struct packed {
    logic       valid;
    logic       fault;
    logic       split;
    logic [5:0] cause;
  } pmp_rsp_t;

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata;
  } pmp_apb_req_t;

  typedef struct packed {
    logic        pready;
    logic        pslverr;
    logic [31:0] prdata;
  } pmp_apb_rsp_t;

  localparam logic [5:0] EXC_INSTR_ACC_FAULT = 6'd1;
  localparam logic [5:0] EXC_LOAD_ACC_FAULT  = 6'd5;
  localparam logic [5:0] EXC_STORE_ACC_FAULT = 6'd7;

  // Byte offsets of the APB register windows
  localparam logic [11:0] APB_CFG_BASE  = 12'h000;
  localparam logic [11:0] APB_ADDR_BASE = 12'h100;
  localparam logic [11:0] APB_MSECCFG   = 12'h200;

  localparam int MSECCFG_RLB_BIT = 2;

  // Software view of a stored pmpaddr under granularity g
  function automatic logic [31:0] pmp_addr_view(logic [31:0] addr, pmp_mode_e mode,
                                                 int unsigned g);
    logic [31:0] res;
    res = addr;
    for (int unsigned b = 0; b < 32; b++) begin
      if (!mode[1] && (b < g)) begin
        res[b] = 1'b0;
      end else if (mode[1] && (b + 1 < g)) begin
        res[b] = 1'b1;
      end
    end
    return res;
  endfunction

endpackage

// File: apb_csr/pmp_apb_fsm.sv
`timescale 1ns/1ps

module pmp_apb_fsm #(
  parameter int NUM_REGIONS = 8
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  pmp_pkg::pmp_apb_req_t   apb_req_i,
  output pmp_pkg::pmp_apb_rsp_t   apb_rsp_o,
  output logic                    reg_we_o,
  output pmp_pkg::pmp_sel_e       reg_sel_o,
  output logic [3:0]              reg_idx_o,
  output logic [31:0]             reg_wdata_o,
  input  logic [31:0]             reg_rdata_i
);

  typedef enum logic [1:0] {
    IDLE,
    SETUP,
    ACCESS
  } state_e;

  // Holds the bus phase of the previous cycle
  state_e state_q;
  state_e state_d;

  logic setup_ph;
  logic access_ph;
  logic mapped;
  logic word_ok;

  assign setup_ph  = apb_req_i.psel && !apb_req_i.penable;
  assign access_ph = apb_req_i.psel && apb_req_i.penable && (state_q == SETUP);

  always_comb begin
    state_d = IDLE;
    if (setup_ph) begin
      state_d = SETUP;
    end else if (access_ph) begin
      state_d = ACCESS;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Address decode into window and word index
  assign word_ok   = (apb_req_i.paddr[1:0] == 2'b00);
  assign reg_idx_o = apb_req_i.paddr[5:2];

  always_comb begin
    reg_sel_o = pmp_pkg::PMP_SEL_CFG;
    mapped    = 1'b0;
    if (apb_req_i.paddr == pmp_pkg::APB_MSECCFG) begin
      reg_sel_o = pmp_pkg::PMP_SEL_MSECCFG;
      mapped    = 1'b1;
    end else if (apb_req_i.paddr[11:8] == pmp_pkg::APB_ADDR_BASE[11:8]) begin
      reg_sel_o = pmp_pkg::PMP_SEL_ADDR;
      mapped    = word_ok && (int'(apb_req_i.paddr[7:2]) < NUM_REGIONS);
    end else if (apb_req_i.paddr[11:8] == pmp_pkg::APB_CFG_BASE[11:8]) begin
      mapped    = word_ok && (int'(apb_req_i.paddr[7:2]) < NUM_REGIONS / 4);
    end
  end

  // Single write strobe in the access phase
  assign reg_we_o    = access_ph && apb_req_i.pwrite && mapped;
  assign reg_wdata_o = apb_req_i.pwdata;

  assign apb_rsp_o.pready  = access_ph;
  assign apb_rsp_o.pslverr = access_ph && !mapped;
  assign apb_rsp_o.prdata  = (access_ph && mapped) ? reg_rdata_i : 32'd0;

endmodule

// File: apb_csr/pmp_csr_regs.sv
`timescale 1ns/1ps

module pmp_csr_regs #(
  parameter int NUM_REGIONS = 8,
  parameter int GRANULARITY = 2
) (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic                                    reg_we_i,
  input  pmp_pkg::pmp_sel_e                       reg_sel_i,
  input  logic [3:0]                              reg_idx_i,
  input  logic [31:0]                             reg_wdata_i,
  output logic [31:0]                             reg_rdata_o,
  output pmp_pkg::pmp_cfg_t [NUM_REGIONS-1:0]     cfg_o,
  output logic [NUM_REGIONS-1:0][31:0]            addr_o,
  output logic                                    rlb_o
);

  pmp_pkg::pmp_cfg_t [NUM_REGIONS-1:0] cfg_q;
  pmp_pkg::pmp_cfg_t [NUM_REGIONS-1:0] cfg_d;
  logic [NUM_REGIONS-1:0][31:0]        addr_q;
  logic [NUM_REGIONS-1:0][31:0]        addr_d;
  logic                                rlb_q;
  logic                                rlb_d;

  logic [NUM_REGIONS-1:0] locked;
  logic [NUM_REGIONS-1:0] tor_above;
  logic [NUM_REGIONS-1:0] addr_blocked;

  // WARL rules for one cfg byte, applied in order
  function automatic pmp_pkg::pmp_cfg_t legalize_cfg(pmp_pkg::pmp_cfg_t old_cfg,
                                                     pmp_pkg::pmp_cfg_t new_cfg,
                                                     logic rlb);
    pmp_pkg::pmp_cfg_t res;
    res = new_cfg;
    if (old_cfg.lock && !rlb) begin
      res = old_cfg;
    end else begin
      // RW=01 is reserved
      if (new_cfg.write && !new_cfg.read) begin
        res.exec  = old_cfg.exec;
        res.write = old_cfg.write;
        res.read  = old_cfg.read;
      end
      if ((GRANULARITY >= 1) && (new_cfg.mode == pmp_pkg::PMP_NA4)) begin
        res.mode = old_cfg.mode;
      end
      // Lock is sticky until reset
      res.lock = new_cfg.lock | old_cfg.lock;
    end
    res.zero = 2'b00;
    return res;
  endfunction

  for (genvar i = 0; i < NUM_REGIONS; i++) begin : g_lock
    assign locked[i] = cfg_q[i].lock;
    if (i < NUM_REGIONS - 1) begin : g_tor
      assign tor_above[i] = cfg_q[i+1].lock && (cfg_q[i+1].mode == pmp_pkg::PMP_TOR);
    end else begin : g_top
      assign tor_above[i] = 1'b0;
    end
  end

  assign addr_blocked = (locked | tor_above) & {NUM_REGIONS{~rlb_q}};

  always_comb begin
    cfg_d  = cfg_q;
    addr_d = addr_q;
    rlb_d  = rlb_q;
    if (reg_we_i) begin
      unique case (reg_sel_i)
        pmp_pkg::PMP_SEL_CFG: begin
          for (int i = 0; i < NUM_REGIONS; i++) begin
            if (4'(i / 4) == reg_idx_i) begin
              cfg_d[i] = legalize_cfg(cfg_q[i],
                                      pmp_pkg::pmp_cfg_t'(reg_wdata_i[8*(i%4) +: 8]),
                                      rlb_q);
            end
          end
        end
        pmp_pkg::PMP_SEL_ADDR: begin
          for (int i = 0; i < NUM_REGIONS; i++) begin
            if ((4'(i) == reg_idx_i) && !addr_blocked[i]) begin
              addr_d[i] = reg_wdata_i;
            end
          end
        end
        pmp_pkg::PMP_SEL_MSECCFG: begin
          // RLB may only be set while nothing is locked
          if (rlb_q || !(|locked)) begin
            rlb_d = reg_wdata_i[pmp_pkg::MSECCFG_RLB_BIT];
          end
        end
        default: begin
          rlb_d = rlb_q;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_q  <= '0;
      addr_q <= '0;
      rlb_q  <= 1'b0;
    end else begin
      cfg_q  <= cfg_d;
      addr_q <= addr_d;
      rlb_q  <= rlb_d;
    end
  end

  // Read-back with granularity masking
  always_comb begin
    reg_rdata_o = 32'd0;
    unique case (reg_sel_i)
      pmp_pkg::PMP_SEL_CFG: begin
        for (int i = 0; i < NUM_REGIONS; i++) begin
          if (4'(i / 4) == reg_idx_i) begin
            reg_rdata_o[8*(i%4) +: 8] = cfg_q[i];
          end
        end
      end
      pmp_pkg::PMP_SEL_ADDR: begin
        for (int i = 0; i < NUM_REGIONS; i++) begin
          if (4'(i) == reg_idx_i) begin
            reg_rdata_o = pmp_pkg::pmp_addr_view(addr_q[i], cfg_q[i].mode, GRANULARITY);
          end
        end
      end
      pmp_pkg::PMP_SEL_MSECCFG: begin
        reg_rdata_o[pmp_pkg::MSECCFG_RLB_BIT] = rlb_q;
      end
      default: begin
        reg_rdata_o = 32'd0;
      end
    endcase
  end

  assign cfg_o  = cfg_q;
  assign addr_o = addr_q;
  assign rlb_o  = rlb_q;

endmodule

// File: check/pmp_region_match.sv
`timescale 1ns/1ps

module pmp_region_match #(
  parameter int NUM_REGIONS = 8,
  parameter int GRANULARITY = 2
) (
  input  pmp_pkg::pmp_cfg_t [NUM_REGIONS-1:0] cfg_i,
  input  logic [NUM_REGIONS-1:0][31:0]        addr_i,
  input  logic [31:0]                         chk_addr_i,
  input  pmp_pkg::pmp_acc_e                   acc_i,
  input  pmp_pkg::pmp_priv_e                  priv_i,
  output logic                                allow_o
);

  logic [31:0]                  chk_word;
  logic [NUM_REGIONS-1:0][31:0] addr_view;
  logic [NUM_REGIONS-1:0]       match;
  pmp_pkg::pmp_cfg_t            hit_cfg;
  logic                         hit;
  logic                         perm;

  // Compare in word units, as pmpaddr holds address bits 33:2
  assign chk_word = {2'b00, chk_addr_i[31:2]};

  for (genvar i = 0; i < NUM_REGIONS; i++) begin : g_entry
    logic [31:0] lower;
    logic [31:0] napot_care;
    logic        tor_hit;
    logic        na4_hit;
    logic        napot_hit;

    assign addr_view[i] = pmp_pkg::pmp_addr_view(addr_i[i], cfg_i[i].mode, GRANULARITY);

    if (i == 0) begin : g_first
      assign lower = 32'd0;
    end else begin : g_rest
      assign lower = addr_view[i-1];
    end

    // Trailing ones and the zero above them are don't-care bits
    assign napot_care = ~(addr_view[i] ^ (addr_view[i] + 32'd1));

    assign tor_hit   = (chk_word >= lower) && (chk_word < addr_view[i]);
    assign na4_hit   = (chk_word == addr_view[i]);
    assign napot_hit = (((chk_word ^ addr_view[i]) & napot_care) == 32'd0);

    assign match[i] = (cfg_i[i].mode == pmp_pkg::PMP_TOR)   ? tor_hit   :
                      (cfg_i[i].mode == pmp_pkg::PMP_NA4)   ? na4_hit   :
                      (cfg_i[i].mode == pmp_pkg::PMP_NAPOT) ? napot_hit : 1'b0;
  end

  // Lowest matching index decides
  always_comb begin
    hit     = 1'b0;
    hit_cfg = '0;
    for (int i = NUM_REGIONS - 1; i >= 0; i--) begin
      if (match[i]) begin
        hit     = 1'b1;
        hit_cfg = cfg_i[i];
      end
    end
  end

  always_comb begin
    unique case (acc_i)
      pmp_pkg::PMP_ACC_EXEC:  perm = hit_cfg.exec;
      pmp_pkg::PMP_ACC_READ:  perm = hit_cfg.read;
      pmp_pkg::PMP_ACC_WRITE: perm = hit_cfg.write;
      default:                perm = 1'b0;
    endcase
  end

  always_comb begin
    if (hit) begin
      allow_o = ((priv_i == pmp_pkg::PMP_PRIV_M) && !hit_cfg.lock) || perm;
    end else begin
      // No match, M is allowed and U denied
      allow_o = (priv_i == pmp_pkg::PMP_PRIV_M);
    end
  end

endmodule

// File: check/pmp_access_check.sv
`timescale 1ns/1ps

module pmp_access_check #(
  parameter int NUM_REGIONS = 8,
  parameter int GRANULARITY = 2
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  pmp_pkg::pmp_cfg_t [NUM_REGIONS-1:0] cfg_i,
  input  logic [NUM_REGIONS-1:0][31:0]        addr_i,
  input  pmp_pkg::pmp_req_t                   check_req_i,
  output pmp_pkg::pmp_rsp_t                   check_rsp_o
);

  logic [31:0] upper_addr;
  logic        allow_lo;
  logic        allow_hi;
  logic        split;
  logic        fault;
  logic [5:0]  cause;

  logic        valid_q;
  logic        fault_q;
  logic        split_q;
  logic [5:0]  cause_q;

  // Address of the top byte of the access
  assign upper_addr = check_req_i.addr + ((32'd1 << check_req_i.size) - 32'd1);

  pmp_region_match #(
    .NUM_REGIONS (NUM_REGIONS),
    .GRANULARITY (GRANULARITY)
  ) u_match_lo (
    .cfg_i      (cfg_i),
    .addr_i     (addr_i),
    .chk_addr_i (check_req_i.addr),
    .acc_i      (check_req_i.acc),
    .priv_i     (check_req_i.priv),
    .allow_o    (allow_lo)
  );

  pmp_region_match #(
    .NUM_REGIONS (NUM_REGIONS),
    .GRANULARITY (GRANULARITY)
  ) u_match_hi (
    .cfg_i      (cfg_i),
    .addr_i     (addr_i),
    .chk_addr_i (upper_addr),
    .acc_i      (check_req_i.acc),
    .priv_i     (check_req_i.priv),
    .allow_o    (allow_hi)
  );

  assign split = (upper_addr[31:2] != check_req_i.addr[31:2]);
  assign fault = !(allow_lo && allow_hi);

  always_comb begin
    cause = 6'd0;
    if (fault) begin
      unique case (check_req_i.acc)
        pmp_pkg::PMP_ACC_EXEC:  cause = pmp_pkg::EXC_INSTR_ACC_FAULT;
        pmp_pkg::PMP_ACC_READ:  cause = pmp_pkg::EXC_LOAD_ACC_FAULT;
        pmp_pkg::PMP_ACC_WRITE: cause = pmp_pkg::EXC_STORE_ACC_FAULT;
        default:                cause = 6'd0;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= check_req_i.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (check_req_i.valid) begin
      fault_q <= fault;
      split_q <= split;
      cause_q <= cause;
    end
  end

  assign check_rsp_o = '{valid: valid_q, fault: fault_q, split: split_q, cause: cause_q};

endmodule

// File: rtl/pmp_unit.sv
`timescale 1ns/1ps

module pmp_unit #(
  parameter int NUM_REGIONS = 8,
  parameter int GRANULARITY = 2
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  pmp_pkg::pmp_apb_req_t apb_req_i,
  output pmp_pkg::pmp_apb_rsp_t apb_rsp_o,
  input  pmp_pkg::pmp_req_t     check_req_i,
  output pmp_pkg::pmp_rsp_t     check_rsp_o
);

  logic                                reg_we;
  pmp_pkg::pmp_sel_e                   reg_sel;
  logic [3:0]                          reg_idx;
  logic [31:0]                         reg_wdata;
  logic [31:0]                         reg_rdata;
  pmp_pkg::pmp_cfg_t [NUM_REGIONS-1:0] cfg;
  logic [NUM_REGIONS-1:0][31:0]        addr;
  // Rule locking bypass state from mseccfg
  logic                                rlb;

  pmp_apb_fsm #(
    .NUM_REGIONS (NUM_REGIONS)
  ) u_apb_fsm (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .apb_req_i   (apb_req_i),
    .apb_rsp_o   (apb_rsp_o),
    .reg_we_o    (reg_we),
    .reg_sel_o   (reg_sel),
    .reg_idx_o   (reg_idx),
    .reg_wdata_o (reg_wdata),
    .reg_rdata_i (reg_rdata)
  );

  pmp_csr_regs #(
    .NUM_REGIONS (NUM_REGIONS),
    .GRANULARITY (GRANULARITY)
  ) u_csr_regs (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .reg_we_i    (reg_we),
    .reg_sel_i   (reg_sel),
    .reg_idx_i   (reg_idx),
    .reg_wdata_i (reg_wdata),
    .reg_rdata_o (reg_rdata),
    .cfg_o       (cfg),
    .addr_o      (addr),
    .rlb_o       (rlb)
  );

  pmp_access_check #(
    .NUM_REGIONS (NUM_REGIONS),
    .GRANULARITY (GRANULARITY)
  ) u_access_check (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cfg_i       (cfg),
    .addr_i      (addr),
    .check_req_i (check_req_i),
    .check_rsp_o (check_rsp_o)
  );

endmodule

// File: verif/pmp_scoreboard.sv
`timescale 1ns/1ps

module pmp_scoreboard #(
  parameter int NUM_REGIONS = 8,
  parameter int GRANULARITY = 2
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  pmp_pkg::pmp_apb_req_t apb_req_i,
  input  pmp_pkg::pmp_apb_rsp_t apb_rsp_i,
  input  pmp_pkg::pmp_req_t     check_req_i,
  input  pmp_pkg::pmp_rsp_t     check_rsp_i,
  output int                    apb_errs_o,
  output int                    check_errs_o,
  output int                    compares_o
);

  // Shadow registers, cfg as raw bytes: L, 2 zero bits, A[1:0], X, W, R
  logic [7:0]  cfg_m  [NUM_REGIONS];
  logic [31:0] addr_m [NUM_REGIONS];
  logic        rlb_m;

  logic              setup_q;
  logic              pend_valid;
  pmp_pkg::pmp_rsp_t pend_rsp;

  int apb_errs   = 0;
  int check_errs = 0;
  int compares   = 0;

  assign apb_errs_o   = apb_errs;
  assign check_errs_o = check_errs;
  assign compares_o   = compares;

  function automatic logic [31:0] masked_addr(logic [31:0] a, logic [1:0] mode);
    logic [31:0] low;
    low = (32'd1 << GRANULARITY) - 32'd1;
    if (mode == 2'b11) begin
      return a | (low >> 1);
    end
    if (mode == 2'b10) begin
      return a;
    end
    return a & ~low;
  endfunction

  function automatic logic [7:0] legal_cfg(logic [7:0] old_b, logic [7:0] new_b, logic rlb);
    logic [7:0] r;
    if (old_b[7] && !rlb) begin
      return old_b;
    end
    r = new_b;
    if (new_b[1:0] == 2'b10) begin
      r[2:0] = old_b[2:0];
    end
    if ((GRANULARITY >= 1) && (new_b[4:3] == 2'b10)) begin
      r[4:3] = old_b[4:3];
    end
    r[7]   = new_b[7] | old_b[7];
    r[6:5] = 2'b00;
    return r;
  endfunction

  // Allow decision for one byte address, lowest matching entry first
  function automatic logic byte_allowed(logic [31:0] byte_addr, logic [1:0] acc,
                                        logic [1:0] priv);
    logic [63:0] word;
    logic [63:0] lo;
    logic [63:0] hi;
    logic [63:0] span;
    logic [31:0] nap;
    logic [7:0]  c;
    logic        perm;
    int          t;
    word = {34'd0, byte_addr[31:2]};
    for (int i = 0; i < NUM_REGIONS; i++) begin
      c  = cfg_m[i];
      lo = 64'd0;
      hi = 64'd0;
      if (c[4:3] == 2'b01) begin
        if (i > 0) begin
          lo = {32'd0, masked_addr(addr_m[i-1], cfg_m[i-1][4:3])};
        end
        hi = {32'd0, masked_addr(addr_m[i], 2'b01)};
      end else if (c[4:3] == 2'b10) begin
        lo = {32'd0, addr_m[i]};
        hi = lo + 64'd1;
      end else if (c[4:3] == 2'b11) begin
        nap = masked_addr(addr_m[i], 2'b11);
        t = 0;
        while ((t < 32) && nap[t]) begin
          t++;
        end
        span = 64'd1 << (t + 1);
        lo   = {32'd0, nap} & ~(span - 64'd1);
        hi   = lo + span;
      end
      if ((word >= lo) && (word < hi)) begin
        perm = (acc == 2'b00) ? c[2] : (acc == 2'b01) ? c[0] : c[1];
        return ((priv == 2'b11) && !c[7]) || perm;
      end
    end
    return priv == 2'b11;
  endfunction

  function automatic pmp_pkg::pmp_rsp_t expected_rsp(pmp_pkg::pmp_req_t req);
    pmp_pkg::pmp_rsp_t r;
    logic [31:0]       upper;
    logic              ok;
    upper = req.addr + (32'd1 << req.size) - 32'd1;
    ok = byte_allowed(req.addr, req.acc, req.priv) && byte_allowed(upper, req.acc, req.priv);
    r.valid = 1'b1;
    r.fault = !ok;
    r.split = (upper[31:2] != req.addr[31:2]);
    r.cause = 6'd0;
    if (!ok) begin
      r.cause = (req.acc == 2'b00) ? pmp_pkg::EXC_INSTR_ACC_FAULT :
                (req.acc == 2'b01) ? pmp_pkg::EXC_LOAD_ACC_FAULT : pmp_pkg::EXC_STORE_ACC_FAULT;
    end
    return r;
  endfunction

  function automatic pmp_pkg::pmp_apb_rsp_t expected_apb(logic [11:0] pa);
    pmp_pkg::pmp_apb_rsp_t r;
    int                    idx;
    r   = '{pready: 1'b1, pslverr: 1'b1, prdata: 32'd0};
    idx = int'(pa[7:2]);
    if (pa == pmp_pkg::APB_MSECCFG) begin
      r.pslverr   = 1'b0;
      r.prdata[2] = rlb_m;
    end else if ((pa[11:8] == 4'h1) && (pa[1:0] == 2'b00) && (idx < NUM_REGIONS)) begin
      r.pslverr = 1'b0;
      r.prdata  = masked_addr(addr_m[idx], cfg_m[idx][4:3]);
    end else if ((pa[11:8] == 4'h0) && (pa[1:0] == 2'b00) && (idx < NUM_REGIONS / 4)) begin
      r.pslverr = 1'b0;
      for (int k = 0; k < 4; k++) begin
        r.prdata[8*k +: 8] = cfg_m[4*idx + k];
      end
    end
    return r;
  endfunction

  task automatic apply_write(logic [11:0] pa, logic [31:0] wd);
    pmp_pkg::pmp_apb_rsp_t r;
    int                    idx;
    logic                  any_lock;
    logic                  blocked;
    r        = expected_apb(pa);
    idx      = int'(pa[7:2]);
    any_lock = 1'b0;
    for (int i = 0; i < NUM_REGIONS; i++) begin
      any_lock |= cfg_m[i][7];
    end
    if (!r.pslverr) begin
      if (pa == pmp_pkg::APB_MSECCFG) begin
        if (rlb_m || !any_lock) begin
          rlb_m = wd[2];
        end
      end else if (pa[11:8] == 4'h1) begin
        blocked = cfg_m[idx][7];
        if (idx + 1 < NUM_REGIONS) begin
          blocked |= cfg_m[idx+1][7] && (cfg_m[idx+1][4:3] == 2'b01);
        end
        if (!blocked || rlb_m) begin
          addr_m[idx] = wd;
        end
      end else begin
        for (int k = 0; k < 4; k++) begin
          cfg_m[4*idx + k] = legal_cfg(cfg_m[4*idx + k], wd[8*k +: 8], rlb_m);
        end
      end
    end
  endtask

  function automatic int mismatch(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error: %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
      return 1;
    end
    return 0;
  endfunction

  always @(posedge clk_i or negedge rst_ni) begin
    pmp_pkg::pmp_apb_rsp_t exp_apb;
    logic                  access;
    if (!rst_ni) begin
      for (int i = 0; i < NUM_REGIONS; i++) begin
        cfg_m[i]  = 8'd0;
        addr_m[i] = 32'd0;
      end
      rlb_m      = 1'b0;
      setup_q    = 1'b0;
      pend_valid = 1'b0;
    end else begin
      // Response to the request sampled one edge earlier
      check_errs += mismatch("check_rsp_o.valid", check_rsp_i.valid, pend_valid);
      if (pend_valid && check_rsp_i.valid) begin
        check_errs += mismatch("check_rsp_o.fault", check_rsp_i.fault, pend_rsp.fault);
        check_errs += mismatch("check_rsp_o.split", check_rsp_i.split, pend_rsp.split);
        check_errs += mismatch("check_rsp_o.cause", check_rsp_i.cause, pend_rsp.cause);
        compares++;
      end
      if (check_req_i.valid) begin
        pend_rsp = expected_rsp(check_req_i);
      end
      pend_valid = check_req_i.valid;

      access = apb_req_i.psel && apb_req_i.penable && setup_q;
      if (access) begin
        exp_apb = expected_apb(apb_req_i.paddr);
        apb_errs += mismatch("apb_rsp_o.pready", apb_rsp_i.pready, exp_apb.pready);
        apb_errs += mismatch("apb_rsp_o.pslverr", apb_rsp_i.pslverr, exp_apb.pslverr);
        if (apb_req_i.pwrite) begin
          apply_write(apb_req_i.paddr, apb_req_i.pwdata);
        end else begin
          apb_errs += mismatch("apb_rsp_o.prdata", apb_rsp_i.prdata, exp_apb.prdata);
        end
        compares++;
      end
      setup_q = apb_req_i.psel && !apb_req_i.penable;
    end
  end

endmodule

// File: verif/pmp_unit_chk.sv
`timescale 1ns/1ps

module pmp_unit_chk #(
  parameter int NUM_REGIONS = 8
) (
  input logic                                clk_i,
  input logic                                rst_ni,
  input pmp_pkg::pmp_apb_req_t               apb_req_i,
  input pmp_pkg::pmp_apb_rsp_t               apb_rsp_i,
  input pmp_pkg::pmp_req_t                   check_req_i,
  input pmp_pkg::pmp_rsp_t                   check_rsp_i,
  input pmp_pkg::pmp_cfg_t [NUM_REGIONS-1:0] cfg_i,
  input logic                                rlb_i
);

  int fail_count = 0;

  // pready only in the cycle after a setup phase
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(apb_rsp_i.pready) |->
      (apb_req_i.psel && apb_req_i.penable && $past(apb_req_i.psel && !apb_req_i.penable)))
  else begin
    $error("pready rose outside an APB access phase");
    fail_count++;
  end

  for (genvar i = 0; i < NUM_REGIONS; i++) begin : g_lock
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      (cfg_i[i].lock && !rlb_i) |=> $stable(cfg_i[i]))
    else begin
      $error("locked pmpcfg entry %0d changed while RLB was clear", i);
      fail_count++;
    end
  end

  // One cycle of check latency
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    check_rsp_i.valid == $past(check_req_i.valid))
  else begin
    $error("check response valid does not follow the request by one cycle");
    fail_count++;
  end

endmodule

bind pmp_unit pmp_unit_chk #(
  .NUM_REGIONS (NUM_REGIONS)
) u_chk (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .apb_req_i   (apb_req_i),
  .apb_rsp_i   (apb_rsp_o),
  .check_req_i (check_req_i),
  .check_rsp_i (check_rsp_o),
  .cfg_i       (cfg),
  .rlb_i       (rlb)
);

// File: verif/pmp_tb.sv
`timescale 1ns/1ps

module pmp_tb;

  localparam int NUM_REGIONS = 8;
  localparam int GRANULARITY = 2;
  localparam int WAIT_LIMIT  = 10;

  logic                  clk = 1'b0;
  logic                  rst_n;
  pmp_pkg::pmp_apb_req_t apb_req;
  pmp_pkg::pmp_apb_rsp_t apb_rsp;
  pmp_pkg::pmp_req_t     check_req;
  pmp_pkg::pmp_rsp_t     check_rsp;

  int apb_errs;
  int check_errs;
  int compares;
  int tb_errs = 0;

  always #5 clk = ~clk;

  pmp_unit #(
    .NUM_REGIONS (NUM_REGIONS),
    .GRANULARITY (GRANULARITY)
  ) uut (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .apb_req_i   (apb_req),
    .apb_rsp_o   (apb_rsp),
    .check_req_i (check_req),
    .check_rsp_o (check_rsp)
  );

  pmp_scoreboard #(
    .NUM_REGIONS (NUM_REGIONS),
    .GRANULARITY (GRANULARITY)
  ) u_scoreboard (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .apb_req_i    (apb_req),
    .apb_rsp_i    (apb_rsp),
    .check_req_i  (check_req),
    .check_rsp_i  (check_rsp),
    .apb_errs_o   (apb_errs),
    .check_errs_o (check_errs),
    .compares_o   (compares)
  );

  task automatic apply_reset();
    @(posedge clk);
    rst_n <= 1'b0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
  endtask

  // One APB transfer with setup and access phases
  task automatic apb_xfer(input logic [11:0] addr, input logic write,
                          input logic [31:0] wdata, output logic [31:0] rdata);
    int cnt;
    @(posedge clk);
    apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
    @(posedge clk);
    apb_req.penable <= 1'b1;
    cnt = 0;
    do begin
      @(posedge clk);
      cnt++;
    end while (!apb_rsp.pready && (cnt < WAIT_LIMIT));
    if (!apb_rsp.pready) begin
      $display("Timeout waiting for pready on APB address 0x%h", addr);
      tb_errs++;
    end
    rdata = apb_rsp.prdata;
    apb_req.psel    <= 1'b0;
    apb_req.penable <= 1'b0;
  endtask

  task automatic apb_write(input logic [11:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    apb_xfer(addr, 1'b1, data, unused);
  endtask

  task automatic apb_read(input logic [11:0] addr);
    logic [31:0] unused;
    apb_xfer(addr, 1'b0, 32'd0, unused);
  endtask

  task automatic expect_read(input logic [11:0] addr, input logic [31:0] exp);
    logic [31:0] got;
    apb_xfer(addr, 1'b0, 32'd0, got);
    if (got !== exp) begin
      $display("** Error: prdata at 0x%h got 0x%h expected 0x%h", addr, got, exp);
      tb_errs++;
    end
  endtask

  task automatic send_check(input logic [31:0] addr, input pmp_pkg::pmp_acc_e acc,
                            input pmp_pkg::pmp_priv_e priv, input logic [1:0] size);
    @(posedge clk);
    check_req <= '{valid: 1'b1, addr: addr, acc: acc, priv: priv, size: size};
  endtask

  // Drop valid and wait for the last response to retire
  task automatic end_checks();
    int cnt;
    @(posedge clk);
    check_req.valid <= 1'b0;
    cnt = 0;
    do begin
      @(posedge clk);
      cnt++;
    end while (check_rsp.valid && (cnt < WAIT_LIMIT));
    if (check_rsp.valid) begin
      $display("Timeout waiting for the check response to go idle");
      tb_errs++;
    end
  endtask

  task automatic cfg_warl_writes();
    // NA4, reserved RW=01 and zero bits together keep the old byte
    apb_write(12'h000, 32'h0000_000d);
    apb_write(12'h000, 32'h0000_0072);
    expect_read(12'h000, 32'h0000_000d);
    for (int n = 0; n < 24; n++) begin
      apb_write(12'(4 * (n % 2)), $urandom & 32'h7f7f_7f7f);
      apb_read(12'(4 * (n % 2)));
    end
  endtask

  task automatic addr_masking_reads();
    apb_write(12'h000, 32'h0018_0000);
    apb_write(12'h108, 32'h1234_567a);
    expect_read(12'h108, 32'h1234_567b);
    apb_write(12'h000, 32'h0008_0000);
    expect_read(12'h108, 32'h1234_5678);
    apb_write(12'h000, 32'h0018_0000);
    expect_read(12'h108, 32'h1234_567b);
    apb_write(12'h10c, 32'hffff_ffff);
    expect_read(12'h10c, 32'hffff_fffc);
    for (int i = 0; i < NUM_REGIONS; i++) begin
      apb_write(12'h100 + 12'(4 * i), $urandom);
      apb_read(12'h100 + 12'(4 * i));
    end
  endtask

  task automatic unmapped_accesses();
    apb_write(12'h300, 32'hdead_beef);
    apb_read(12'h300);
    apb_write(12'h008, 32'hffff_ffff);
    apb_write(12'h120, 32'h0000_1234);
    apb_write(12'h102, 32'h0000_5678);
    apb_read(12'h204);
    apb_read(12'h000);
    apb_read(12'h004);
    for (int i = 0; i < NUM_REGIONS; i++) begin
      apb_read(12'h100 + 12'(4 * i));
    end
  endtask

  task automatic lock_sequence();
    apply_reset();
    apb_write(12'h100, 32'h0000_0100);
    apb_write(12'h104, 32'h0000_0200);
    apb_write(12'h000, 32'h0000_8900);
    // Entry 1 is locked TOR, so entries 0 and 1 are frozen
    apb_write(12'h104, 32'h0000_0300);
    apb_write(12'h100, 32'h0000_0050);
    apb_write(12'h000, 32'h0000_0f00);
    expect_read(12'h104, 32'h0000_0200);
    expect_read(12'h100, 32'h0000_0100);
    expect_read(12'h000, 32'h0000_8900);
    apb_write(12'h200, 32'h0000_0004);
    expect_read(12'h200, 32'h0000_0000);
    apply_reset();
    expect_read(12'h000, 32'h0000_0000);
    expect_read(12'h104, 32'h0000_0000);
    expect_read(12'h200, 32'h0000_0000);
    // RLB first, then the lock no longer blocks edits
    apb_write(12'h200, 32'h0000_0004);
    expect_read(12'h200, 32'h0000_0004);
    apb_write(12'h000, 32'h0000_8900);
    apb_write(12'h104, 32'h0000_0300);
    expect_read(12'h104, 32'h0000_0300);
    apb_write(12'h000, 32'h0000_8b00);
    expect_read(12'h000, 32'h0000_8b00);
    apb_write(12'h200, 32'h0000_0000);
    apb_write(12'h104, 32'h0000_0400);
    expect_read(12'h104, 32'h0000_0300);
    apply_reset();
  endtask

  task automatic program_regions();
    apb_write(12'h100, 32'h0000_0400);
    apb_write(12'h104, 32'h0000_09ff);
    apb_write(12'h108, 32'h0000_07ff);
    apb_write(12'h10c, 32'h0000_0c00);
    apb_write(12'h110, 32'h0000_101f);
    apb_write(12'h000, 32'h0f1c_1b09);
    apb_write(12'h004, 32'h0000_0099);
  endtask

  task automatic random_checks(input int count);
    logic [31:0]        a;
    pmp_pkg::pmp_acc_e  acc;
    pmp_pkg::pmp_priv_e priv;
    for (int n = 0; n < count; n++) begin
      a    = (($urandom % 8) == 0) ? $urandom : ($urandom % 32'h6000);
      acc  = pmp_pkg::pmp_acc_e'(2'($urandom % 3));
      priv = (($urandom % 2) == 0) ? pmp_pkg::PMP_PRIV_U : pmp_pkg::PMP_PRIV_M;
      send_check(a, acc, priv, 2'($urandom % 3));
    end
    end_checks();
  endtask

  task automatic split_checks();
    send_check(32'h0000_0ffe, pmp_pkg::PMP_ACC_READ, pmp_pkg::PMP_PRIV_U, 2'd2);
    send_check(32'h0000_2ffe, pmp_pkg::PMP_ACC_READ, pmp_pkg::PMP_PRIV_U, 2'd2);
    send_check(32'h0000_2fff, pmp_pkg::PMP_ACC_WRITE, pmp_pkg::PMP_PRIV_U, 2'd1);
    send_check(32'h0000_40fe, pmp_pkg::PMP_ACC_READ, pmp_pkg::PMP_PRIV_M, 2'd2);
    send_check(32'h0000_40fe, pmp_pkg::PMP_ACC_WRITE, pmp_pkg::PMP_PRIV_M, 2'd2);
    send_check(32'h0000_0ffc, pmp_pkg::PMP_ACC_READ, pmp_pkg::PMP_PRIV_U, 2'd2);
    end_checks();
  endtask

  initial begin
    int unsigned seed_ret;
    int          asserts;
    int          total;
    rst_n     = 1'b0;
    apb_req   = '0;
    check_req = '0;
    seed_ret  = $urandom(32'hb4ee_b98e);
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;

    cfg_warl_writes();
    addr_masking_reads();
    unmapped_accesses();
    lock_sequence();
    program_regions();
    random_checks(200);
    split_checks();
    @(posedge clk);

    asserts = uut.u_chk.fail_count;
    total   = apb_errs + check_errs + asserts + tb_errs;
    $display("APB errors %0d, check errors %0d, assertion failures %0d, tb errors %0d, compares %0d",
             apb_errs, check_errs, asserts, tb_errs, compares);
    if ((total == 0) && (compares > 0)) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: files.f
common/pmp_pkg.sv
apb_csr/pmp_apb_fsm.sv
apb_csr/pmp_csr_regs.sv
check/pmp_region_match.sv
check/pmp_access_check.sv
rtl/pmp_unit.sv
verif/pmp_scoreboard.sv
verif/pmp_unit_chk.sv
verif/pmp_tb.sv

// File: Bender.yml
package:
  name: pmp_unit

sources:
  - common/pmp_pkg.sv
  - apb_csr/pmp_apb_fsm.sv
  - apb_csr/pmp_csr_regs.sv
  - check/pmp_region_match.sv
  - check/pmp_access_check.sv
  - rtl/pmp_unit.sv
  - target: test
    files:
      - verif/pmp_scoreboard.sv
      - verif/pmp_unit_chk.sv
      - verif/pmp_tb.sv
